// File: desc_allocator.sv
`timescale 1ns/1ps

module desc_allocator (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic                                    stage_valid,
  input  logic [sched_pkg::PORT_WIDTH-1:0]        stage_port,
  input  logic [sched_pkg::CORE_ID_WIDTH-1:0]     stage_core,
  input  logic [sched_pkg::HASH_WIDTH-1:0]        stage_hash,
  output logic                                    stage_advance,
  input  logic [sched_pkg::CORE_COUNT-1:0]        slot_avail,
  input  logic [sched_pkg::SLOT_WIDTH-1:0]        slot_head [sched_pkg::CORE_COUNT],
  output logic                                    pop_valid,
  output logic [sched_pkg::CORE_ID_WIDTH-1:0]     pop_core,
  input  logic [sched_pkg::CORE_COUNT-1:0]        income_cores,
  output logic                                    desc_valid,
  output logic [sched_pkg::PORT_WIDTH-1:0]        desc_port,
  output logic [sched_pkg::CORE_ID_WIDTH-1:0]     desc_core,
  output logic [sched_pkg::SLOT_WIDTH-1:0]        desc_slot,
  output logic [sched_pkg::HASH_WIDTH-1:0]        desc_hash,
  output logic                                    desc_drop,
  input  logic                                    desc_ready,
  output logic                                    drop_valid,
  output logic [sched_pkg::PORT_WIDTH-1:0]        drop_port
);

  import sched_pkg::*;

  logic core_ok;

  // Output register is free when empty or being taken by the sink
  assign stage_advance = stage_valid && (!desc_valid || desc_ready);

  // Core must be open for interface traffic and hold a free slot
  assign core_ok = income_cores[stage_core] && slot_avail[stage_core];

  assign pop_valid  = stage_advance && core_ok;
  assign pop_core   = stage_core;
  assign drop_valid = stage_advance && !core_ok;
  assign drop_port  = stage_port;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      desc_valid <= 1'b0;
    end else if (stage_advance) begin
      desc_valid <= 1'b1;
    end else if (desc_ready) begin
      desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_advance) begin
      desc_port <= stage_port;
      desc_core <= stage_core;
      desc_hash <= stage_hash;
      desc_drop <= !core_ok;
      desc_slot <= core_ok ? slot_head[stage_core] : '0;
    end
  end

  a_desc_stable: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && !desc_ready |=> desc_valid &&
      $stable({desc_port, desc_core, desc_slot, desc_hash, desc_drop}))
    else $error("descriptor changed under back-pressure");

endmodule

// File: flow_port_arbiter.sv
`timescale 1ns/1ps

module flow_port_arbiter (
  input  logic                                                  clk,
  input  logic                                                  rst_r,
  input  logic [sched_pkg::INTERFACE_COUNT-1:0]                 req_valid,
  input  logic [sched_pkg::HASH_WIDTH-1:0]                      req_hash [sched_pkg::INTERFACE_COUNT],
  output logic [sched_pkg::INTERFACE_COUNT-1:0]                 req_ready,
  output logic                                                  stage_valid,
  output logic [sched_pkg::PORT_WIDTH-1:0]                      stage_port,
  output logic [sched_pkg::CORE_ID_WIDTH-1:0]                   stage_core,
  output logic [sched_pkg::HASH_WIDTH-1:0]                      stage_hash,
  input  logic                                                  stage_advance
);

  import sched_pkg::*;

  logic [PORT_WIDTH-1:0] last_port;
  logic [PORT_WIDTH-1:0] grant_port;
  logic                  grant_found;
  logic                  can_load;
  logic                  take;
  logic [HASH_WIDTH-1:0] grant_hash;

  // Search starts just above the last granted port and wraps around
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_port  = '0;
    for (int k = 1; k <= INTERFACE_COUNT; k++) begin
      idx = (int'(last_port) + k) % INTERFACE_COUNT;
      if (!grant_found && req_valid[idx]) begin
        grant_found = 1'b1;
        grant_port  = PORT_WIDTH'(idx);
      end
    end
  end

  // Stage can take a new request when empty or handing its entry on
  assign can_load = !stage_valid || stage_advance;
  assign take     = can_load && grant_found;

  always_comb begin
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      req_ready[i] = take && (grant_port == PORT_WIDTH'(i));
    end
  end

  assign grant_hash = req_hash[grant_port];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      stage_valid <= 1'b0;
      last_port   <= PORT_WIDTH'(INTERFACE_COUNT - 1);
    end else if (take) begin
      stage_valid <= 1'b1;
      last_port   <= grant_port;
    end else if (stage_advance) begin
      stage_valid <= 1'b0;
    end
  end

  // Payload of the stage register
  always_ff @(posedge clk) begin
    if (take) begin
      stage_port <= grant_port;
      stage_hash <= grant_hash;
      stage_core <= grant_hash[HASH_SEL_OFFSET +: CORE_ID_WIDTH];
    end
  end

  a_ready_onehot: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0(req_ready))
    else $error("more than one interface granted in a cycle");

endmodule

// File: host_regs.sv
`timescale 1ns/1ps

module host_regs (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  logic [sched_pkg::WB_ADR_WIDTH-1:0]    wb_adr,
  input  logic [31:0]                           wb_dat_w,
  output logic [31:0]                           wb_dat_r,
  output logic                                  wb_ack,
  output logic [sched_pkg::CORE_COUNT-1:0]      income_cores,
  input  logic                                  drop_valid,
  input  logic [sched_pkg::PORT_WIDTH-1:0]      drop_port,
  input  logic [sched_pkg::COUNT_WIDTH-1:0]     slot_count [sched_pkg::CORE_COUNT]
);

  import sched_pkg::*;

  logic [31:0]          drop_count [INTERFACE_COUNT];
  logic                 wb_req;
  host_reg_e            reg_code;
  logic [1:0]           reg_index;
  logic [31:0]          rd_value;

  // New access only on the first cycle of cyc and stb
  assign wb_req    = wb_cyc && wb_stb && !wb_ack;
  assign reg_code  = host_reg_e'(wb_adr[WB_ADR_WIDTH-1:2]);
  assign reg_index = wb_adr[1:0];

  always_comb begin
    case (reg_code)
      REG_INCOME_CORES: rd_value = 32'(income_cores);
      REG_SLOT_COUNT:   rd_value = 32'(slot_count[reg_index]);
      REG_DROP_COUNT: begin
        // Index 3 has no interface behind it
        if (int'(reg_index) < INTERFACE_COUNT) begin
          rd_value = drop_count[reg_index];
        end else begin
          rd_value = '0;
        end
      end
      default:          rd_value = UNMAPPED_READ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wb_ack       <= 1'b0;
      income_cores <= '0;
    end else begin
      wb_ack <= wb_req;
      if (wb_req && wb_we && (reg_code == REG_INCOME_CORES)) begin
        income_cores <= wb_dat_w[CORE_COUNT-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_r <= rd_value;
    end
  end

  // Drops counted per receiving interface
  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < INTERFACE_COUNT; i++) begin
        drop_count[i] <= '0;
      end
    end else if (drop_valid) begin
      drop_count[drop_port] <= drop_count[drop_port] + 1'b1;
    end
  end

  a_ack_with_stb: assert property (@(posedge clk) disable iff (rst_r)
    wb_ack |-> wb_stb)
    else $error("wb_ack without wb_stb");

endmodule

// File: pkt_scheduler.sv
`timescale 1ns/1ps

module pkt_scheduler (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [sched_pkg::INTERFACE_COUNT-1:0]   req_valid,
  input  logic [sched_pkg::HASH_WIDTH-1:0]        req_hash [sched_pkg::INTERFACE_COUNT],
  output logic [sched_pkg::INTERFACE_COUNT-1:0]   req_ready,
  input  logic                                    rel_valid,
  input  logic [sched_pkg::CORE_ID_WIDTH-1:0]     rel_core,
  input  logic [sched_pkg::SLOT_WIDTH-1:0]        rel_slot,
  output logic                                    desc_valid,
  output logic [sched_pkg::PORT_WIDTH-1:0]        desc_port,
  output logic [sched_pkg::CORE_ID_WIDTH-1:0]     desc_core,
  output logic [sched_pkg::SLOT_WIDTH-1:0]        desc_slot,
  output logic [sched_pkg::HASH_WIDTH-1:0]        desc_hash,
  output logic                                    desc_drop,
  input  logic                                    desc_ready,
  input  logic                                    wb_cyc,
  input  logic                                    wb_stb,
  input  logic                                    wb_we,
  input  logic [sched_pkg::WB_ADR_WIDTH-1:0]      wb_adr,
  input  logic [31:0]                             wb_dat_w,
  output logic [31:0]                             wb_dat_r,
  output logic                                    wb_ack
);

  import sched_pkg::*;

  logic                     stage_valid;
  logic [PORT_WIDTH-1:0]    stage_port;
  logic [CORE_ID_WIDTH-1:0] stage_core;
  logic [HASH_WIDTH-1:0]    stage_hash;
  logic                     stage_advance;
  logic [CORE_COUNT-1:0]    slot_avail;
  logic [SLOT_WIDTH-1:0]    slot_head [CORE_COUNT];
  logic [COUNT_WIDTH-1:0]   slot_count [CORE_COUNT];
  logic                     pop_valid;
  logic [CORE_ID_WIDTH-1:0] pop_core;
  logic [CORE_COUNT-1:0]    income_cores;
  logic                     drop_valid;
  logic [PORT_WIDTH-1:0]    drop_port;

  flow_port_arbiter flow_port_arbiter_i (
    .clk           (clk),
    .rst_r         (rst_r),
    .req_valid     (req_valid),
    .req_hash      (req_hash),
    .req_ready     (req_ready),
    .stage_valid   (stage_valid),
    .stage_port    (stage_port),
    .stage_core    (stage_core),
    .stage_hash    (stage_hash),
    .stage_advance (stage_advance)
  );

  slot_pool slot_pool_i (
    .clk        (clk),
    .rst_r      (rst_r),
    .rel_valid  (rel_valid),
    .rel_core   (rel_core),
    .rel_slot   (rel_slot),
    .pop_valid  (pop_valid),
    .pop_core   (pop_core),
    .slot_avail (slot_avail),
    .slot_head  (slot_head),
    .slot_count (slot_count)
  );

  desc_allocator desc_allocator_i (
    .clk           (clk),
    .rst_r         (rst_r),
    .stage_valid   (stage_valid),
    .stage_port    (stage_port),
    .stage_core    (stage_core),
    .stage_hash    (stage_hash),
    .stage_advance (stage_advance),
    .slot_avail    (slot_avail),
    .slot_head     (slot_head),
    .pop_valid     (pop_valid),
    .pop_core      (pop_core),
    .income_cores  (income_cores),
    .desc_valid    (desc_valid),
    .desc_port     (desc_port),
    .desc_core     (desc_core),
    .desc_slot     (desc_slot),
    .desc_hash     (desc_hash),
    .desc_drop     (desc_drop),
    .desc_ready    (desc_ready),
    .drop_valid    (drop_valid),
    .drop_port     (drop_port)
  );

  host_regs host_regs_i (
    .clk          (clk),
    .rst_r        (rst_r),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .income_cores (income_cores),
    .drop_valid   (drop_valid),
    .drop_port    (drop_port),
    .slot_count   (slot_count)
  );

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pkt_scheduler -f sim.f -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log
grep -q "^sim passed$" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

// File: sched_pkg.sv
package sched_pkg;

  // Receive side and core topology
  localparam int INTERFACE_COUNT = 3;
  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 8;

  // Field widths
  localparam int HASH_WIDTH    = 32;
  localparam int PORT_WIDTH    = 2;
  localparam int CORE_ID_WIDTH = 2;
  localparam int SLOT_WIDTH    = 3;
  // Pool occupancy from 0 up to SLOT_COUNT inclusive
  localparam int COUNT_WIDTH   = 4;

  // First hash bit that selects the destination core
  localparam int HASH_SEL_OFFSET = 0;

  // Word address bits 4..2 hold the register code and bits 1..0 the core or interface
  localparam int WB_ADR_WIDTH = 5;

  // Host register codes
  typedef enum logic [2:0] {
    REG_INCOME_CORES = 3'd0,
    REG_SLOT_COUNT   = 3'd2,
    REG_DROP_COUNT   = 3'd7
  } host_reg_e;

  // Returned for any code that has no register behind it
  localparam logic [31:0] UNMAPPED_READ = 32'hFEFE_FEFE;

endpackage

// File: sim.f
sched_pkg.sv
flow_port_arbiter.sv
slot_pool.sv
desc_allocator.sv
host_regs.sv
pkt_scheduler.sv
tb_pkt_scheduler.sv

// File: slot_pool.sv
`timescale 1ns/1ps

module slot_pool (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  rel_valid,
  input  logic [sched_pkg::CORE_ID_WIDTH-1:0]   rel_core,
  input  logic [sched_pkg::SLOT_WIDTH-1:0]      rel_slot,
  input  logic                                  pop_valid,
  input  logic [sched_pkg::CORE_ID_WIDTH-1:0]   pop_core,
  output logic [sched_pkg::CORE_COUNT-1:0]      slot_avail,
  output logic [sched_pkg::SLOT_WIDTH-1:0]      slot_head [sched_pkg::CORE_COUNT],
  output logic [sched_pkg::COUNT_WIDTH-1:0]     slot_count [sched_pkg::CORE_COUNT]
);

  import sched_pkg::*;

  function automatic logic [SLOT_WIDTH-1:0] next_ptr(input logic [SLOT_WIDTH-1:0] ptr);
    return (ptr == SLOT_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    logic [SLOT_WIDTH-1:0]  mem [SLOT_COUNT];
    logic [SLOT_WIDTH-1:0]  rd_ptr;
    logic [SLOT_WIDTH-1:0]  wr_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   pop;
    logic                   full;

    assign full = (count == COUNT_WIDTH'(SLOT_COUNT));
    // A release into a full pool is dropped on the floor
    assign push = rel_valid && (rel_core == CORE_ID_WIDTH'(c)) && !full;
    assign pop  = pop_valid && (pop_core == CORE_ID_WIDTH'(c));

    always_ff @(posedge clk) begin
      if (rst_r) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop) begin
          rd_ptr <= next_ptr(rd_ptr);
        end
        if (push && !pop) begin
          count <= count + 1'b1;
        end else if (pop && !push) begin
          count <= count - 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (push) begin
        mem[wr_ptr] <= rel_slot;
      end
    end

    // Head and count are registered state, so a release is visible next cycle
    assign slot_avail[c] = (count != '0);
    assign slot_head[c]  = mem[rd_ptr];
    assign slot_count[c] = count;
  end

  a_no_empty_pop: assert property (@(posedge clk) disable iff (rst_r)
    pop_valid |-> slot_avail[pop_core])
    else $error("slot popped from an empty pool");

endmodule

// File: tb_pkt_scheduler.sv
`timescale 1ns/1ps

module tb_pkt_scheduler;

  import sched_pkg::*;

  localparam int TRAFFIC_CYCLES = 150;
  localparam int RELEASE_COUNT  = 24;
  localparam int WB_ACCESSES    = 40;
  // Three traffic phases, three release bursts and the register accesses
  localparam int PHASE_CYCLES   = 3 * TRAFFIC_CYCLES + 3 * RELEASE_COUNT + 3 * WB_ACCESSES;
  localparam int CYCLE_LIMIT    = 4 * PHASE_CYCLES;
  localparam int DESC_BITS      = PORT_WIDTH + CORE_ID_WIDTH + SLOT_WIDTH + HASH_WIDTH + 1;

  logic                       clk;
  logic                       rst_r;
  logic [INTERFACE_COUNT-1:0] req_valid;
  logic [HASH_WIDTH-1:0]      req_hash [INTERFACE_COUNT];
  logic [INTERFACE_COUNT-1:0] req_ready;
  logic                       rel_valid;
  logic [CORE_ID_WIDTH-1:0]   rel_core;
  logic [SLOT_WIDTH-1:0]      rel_slot;
  logic                       desc_valid;
  logic [PORT_WIDTH-1:0]      desc_port;
  logic [CORE_ID_WIDTH-1:0]   desc_core;
  logic [SLOT_WIDTH-1:0]      desc_slot;
  logic [HASH_WIDTH-1:0]      desc_hash;
  logic                       desc_drop;
  logic                       desc_ready;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [WB_ADR_WIDTH-1:0]    wb_adr;
  logic [31:0]                wb_dat_w;
  logic [31:0]                wb_dat_r;
  logic                       wb_ack;

  // Reference model
  logic [HASH_WIDTH-1:0] port_q [INTERFACE_COUNT][$];
  logic [SLOT_WIDTH-1:0] slot_q [CORE_COUNT][$];
  logic [CORE_COUNT-1:0] model_mask;
  logic [31:0]           model_drops [INTERFACE_COUNT];

  int                    outstanding;
  int                    cycles;
  int                    value_errors;
  int                    other_errors;
  bit                    traffic_on;
  int                    ready_pct;
  bit                    ack_seen;
  logic [31:0]           ack_data;
  bit                    hold_valid;
  logic [DESC_BITS-1:0]  held_desc;

  pkt_scheduler pkt_scheduler_i (
    .clk        (clk),
    .rst_r      (rst_r),
    .req_valid  (req_valid),
    .req_hash   (req_hash),
    .req_ready  (req_ready),
    .rel_valid  (rel_valid),
    .rel_core   (rel_core),
    .rel_slot   (rel_slot),
    .desc_valid (desc_valid),
    .desc_port  (desc_port),
    .desc_core  (desc_core),
    .desc_slot  (desc_slot),
    .desc_hash  (desc_hash),
    .desc_drop  (desc_drop),
    .desc_ready (desc_ready),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Watchdog on the total run length
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("sim failed");
      $finish;
    end
  end

  // Output order decides drop or slot, as pools only change by pops while traffic runs
  task automatic check_descriptor();
    logic [HASH_WIDTH-1:0]    exp_hash;
    logic [CORE_ID_WIDTH-1:0] exp_core;
    logic [SLOT_WIDTH-1:0]    exp_slot;
    bit                       exp_drop;
    if (int'(desc_port) >= INTERFACE_COUNT || port_q[desc_port].size() == 0) begin
      other_errors++;
      $display("descriptor for port %0d without an outstanding request", desc_port);
    end else begin
      exp_hash = port_q[desc_port].pop_front();
      outstanding--;
      exp_core = CORE_ID_WIDTH'((exp_hash >> HASH_SEL_OFFSET) % CORE_COUNT);
      exp_drop = !(model_mask[exp_core] && slot_q[exp_core].size() > 0);
      if (desc_hash !== exp_hash) begin
        value_errors++;
        $display("Fail desc_hash got %h exp %h", desc_hash, exp_hash);
      end
      if (desc_core !== exp_core) begin
        value_errors++;
        $display("Fail desc_core got %h exp %h", desc_core, exp_core);
      end
      if (desc_drop !== exp_drop) begin
        value_errors++;
        $display("Fail desc_drop got %h exp %h", desc_drop, exp_drop);
      end
      if (exp_drop) begin
        model_drops[desc_port] = model_drops[desc_port] + 32'd1;
      end else begin
        exp_slot = slot_q[exp_core].pop_front();
        if (desc_slot !== exp_slot) begin
          value_errors++;
          $display("Fail desc_slot got %h exp %h", desc_slot, exp_slot);
        end
      end
    end
  endtask

  task automatic drive_requests(input logic [INTERFACE_COUNT-1:0] taken);
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      // A pending request holds until it is taken
      if (taken[i] || !req_valid[i]) begin
        if (traffic_on && ($urandom % 2) == 0) begin
          req_valid[i] = 1'b1;
          req_hash[i]  = $urandom;
        end else begin
          req_valid[i] = 1'b0;
        end
      end
    end
    desc_ready = ($urandom % 100) < ready_pct;
  endtask

  // Sample at the falling edge, drive 1 ns after the rising edge
  task automatic tick();
    logic [INTERFACE_COUNT-1:0] taken;
    @(negedge clk);
    taken = req_valid & req_ready;
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      if (taken[i]) begin
        port_q[i].push_back(req_hash[i]);
        outstanding++;
      end
    end
    if (rel_valid && slot_q[rel_core].size() < SLOT_COUNT) begin
      slot_q[rel_core].push_back(rel_slot);
    end
    if (hold_valid) begin
      if (!desc_valid) begin
        other_errors++;
        $display("descriptor withdrawn while the sink was not ready");
      end else if ({desc_port, desc_core, desc_slot, desc_hash, desc_drop} !== held_desc) begin
        value_errors++;
        $display("Fail desc fields got %h exp %h",
                 {desc_port, desc_core, desc_slot, desc_hash, desc_drop}, held_desc);
      end
    end
    hold_valid = desc_valid && !desc_ready;
    held_desc  = {desc_port, desc_core, desc_slot, desc_hash, desc_drop};
    if (desc_valid && desc_ready) begin
      check_descriptor();
    end
    ack_seen = wb_ack;
    ack_data = wb_dat_r;
    @(posedge clk);
    #1;
    drive_requests(taken);
  endtask

  task automatic wb_access(input bit we, input logic [2:0] code, input logic [1:0] index,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = {code, index};
    wb_dat_w = wdata;
    ack_seen = 1'b0;
    while (!ack_seen) begin
      tick();
    end
    rdata  = ack_data;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_mask(input logic [CORE_COUNT-1:0] mask);
    logic [31:0] rd;
    wb_access(1'b1, REG_INCOME_CORES, 2'd0, 32'(mask), rd);
    model_mask = mask;
  endtask

  // A negative core picks a random core per release
  task automatic release_slots(input int count, input int core_sel);
    for (int n = 0; n < count; n++) begin
      rel_valid = 1'b1;
      rel_core  = (core_sel < 0) ? CORE_ID_WIDTH'($urandom % CORE_COUNT)
                                 : CORE_ID_WIDTH'(core_sel);
      rel_slot  = SLOT_WIDTH'($urandom);
      tick();
    end
    rel_valid = 1'b0;
  endtask

  task automatic drain();
    traffic_on = 1'b0;
    while (outstanding != 0 || req_valid != '0) begin
      tick();
    end
  endtask

  task automatic run_traffic(input int count, input int pct);
    traffic_on = 1'b1;
    ready_pct  = pct;
    repeat (count) tick();
    drain();
  endtask

  task automatic check_counts();
    logic [31:0] rd;
    for (int c = 0; c < CORE_COUNT; c++) begin
      wb_access(1'b0, REG_SLOT_COUNT, 2'(c), 32'd0, rd);
      if (rd !== 32'(slot_q[c].size())) begin
        value_errors++;
        $display("Fail slot_count[%0d] got %h exp %h", c, rd, 32'(slot_q[c].size()));
      end
    end
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      wb_access(1'b0, REG_DROP_COUNT, 2'(i), 32'd0, rd);
      if (rd !== model_drops[i]) begin
        value_errors++;
        $display("Fail drop_count[%0d] got %h exp %h", i, rd, model_drops[i]);
      end
    end
  endtask

  initial begin
    logic [31:0] rd;
    void'($urandom(32'h889d_b526));
    rst_r      = 1'b1;
    req_valid  = '0;
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      req_hash[i]    = '0;
      model_drops[i] = '0;
    end
    rel_valid  = 1'b0;
    rel_core   = '0;
    rel_slot   = '0;
    desc_ready = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    model_mask = '0;
    traffic_on = 1'b0;
    ready_pct  = 100;
    hold_valid = 1'b0;
    held_desc  = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_r = 1'b0;

    // Random pool fill, then overflow core 1 past its capacity
    write_mask(4'hF);
    release_slots(RELEASE_COUNT, -1);
    release_slots(SLOT_COUNT + 3, 1);
    check_counts();
    run_traffic(TRAFFIC_CYCLES, 100);
    check_counts();

    // Cores 1 and 3 closed to interface traffic
    write_mask(4'b0101);
    release_slots(RELEASE_COUNT, -1);
    run_traffic(TRAFFIC_CYCLES, 60);
    check_counts();

    // All cores open again, pools run dry under heavy back-pressure
    write_mask(4'hF);
    run_traffic(TRAFFIC_CYCLES, 40);
    check_counts();

    wb_access(1'b0, REG_INCOME_CORES, 2'd0, 32'd0, rd);
    if (rd !== 32'(model_mask)) begin
      value_errors++;
      $display("Fail income_cores got %h exp %h", rd, 32'(model_mask));
    end
    for (int code = 1; code < 7; code++) begin
      if (code != 2) begin
        wb_access(1'b0, 3'(code), 2'd1, 32'd0, rd);
        if (rd !== UNMAPPED_READ) begin
          value_errors++;
          $display("Fail wb_dat_r code %0d got %h exp %h", code, rd, UNMAPPED_READ);
        end
      end
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
